// File: src/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // physical address fields
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 7;
    localparam int OFFSET_W = 5;

    localparam int BANK_NUM = 8;
    localparam int SET_NUM  = 128;
    localparam int LINE_W   = 256;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        uncached;
    } fetch_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_rsp_t;

    // mode 3 is a no-op
    typedef enum logic [1:0] {
        CACOP_IDX_INIT,
        CACOP_IDX_INV,
        CACOP_HIT_INV,
        CACOP_NONE
    } cacop_mode_e;

    typedef struct packed {
        logic        en;
        cacop_mode_e mode;
        logic [31:0] addr;
    } cacop_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        line;  // clear for a single word
    } mem_req_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tagv_t;

    typedef enum logic [1:0] {
        REF_IDLE,
        REF_REQ,
        REF_WAIT,
        REF_DROP
    } refill_state_e;

    typedef enum logic [1:0] {
        UNC_IDLE,
        UNC_REQ,
        UNC_WAIT
    } unc_state_e;

endpackage

`default_nettype wire

// File: src/sdp_ram.sv
`default_nettype none

module sdp_ram #(
    parameter int DEPTH = 128,
    parameter int WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    input  logic [WIDTH-1:0]         wdata_i,
    output logic [WIDTH-1:0]         rdata_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    // read during write returns the old word
    always_ff @(posedge clk) begin
        if (we_i)
            mem[waddr_i] <= wdata_i;
        rdata_o <= mem[raddr_i];
    end

endmodule

`default_nettype wire

// File: src/icache_refill.sv
`default_nettype none

module icache_refill (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush_i,
    input  logic                          miss_i,
    input  logic [31:0]                   miss_addr_i,
    output logic                          req_valid_o,
    output icache_pkg::mem_req_t          req_o,
    input  logic                          req_ready_i,
    input  logic                          rsp_valid_i,
    input  logic [icache_pkg::LINE_W-1:0] rsp_data_i,
    output logic                          fill_o,
    output logic                          fill_live_o,
    output logic [icache_pkg::LINE_W-1:0] fill_data_o,
    output logic                          busy_o
);
    import icache_pkg::*;

    refill_state_e     state_q;
    logic              drop_req_q;  // flushed before the port took the request
    logic [31:OFFSET_W] line_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= REF_IDLE;
            drop_req_q <= 1'b0;
        end else begin
            case (state_q)
                REF_IDLE: if (miss_i) state_q <= REF_REQ;
                REF_REQ: begin
                    if (flush_i) begin
                        state_q    <= REF_DROP;
                        drop_req_q <= !req_ready_i;
                    end else if (req_ready_i) begin
                        state_q <= REF_WAIT;
                    end
                end
                REF_WAIT: begin
                    if (rsp_valid_i)
                        state_q <= REF_IDLE;
                    else if (flush_i)
                        state_q <= REF_DROP;
                end
                default: begin  // drop, line still goes into the arrays
                    if (req_ready_i)
                        drop_req_q <= 1'b0;
                    if (rsp_valid_i)
                        state_q <= REF_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == REF_IDLE && miss_i)
            line_q <= miss_addr_i[31:OFFSET_W];
    end

    assign req_valid_o = state_q == REF_REQ || (state_q == REF_DROP && drop_req_q);
    assign req_o       = '{addr: {line_q, {OFFSET_W{1'b0}}}, line: 1'b1};
    assign fill_o      = rsp_valid_i && (state_q == REF_WAIT || state_q == REF_DROP);
    assign fill_live_o = rsp_valid_i && state_q == REF_WAIT && !flush_i;
    assign fill_data_o = rsp_data_i;
    assign busy_o      = state_q != REF_IDLE;

endmodule

`default_nettype wire

// File: src/icache_uncached.sv
`default_nettype none

module icache_uncached (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush_i,
    input  logic                 start_i,
    input  logic [31:0]          addr_i,
    output logic                 req_valid_o,
    output icache_pkg::mem_req_t req_o,
    input  logic                 req_ready_i,
    input  logic                 rsp_valid_i,
    input  logic [31:0]          rsp_word_i,
    output logic                 done_o,
    output logic [31:0]          word_o,
    output logic                 busy_o
);
    import icache_pkg::*;

    unc_state_e  state_q;
    logic        drop_q;  // fetch flushed, swallow the word
    logic [31:0] addr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= UNC_IDLE;
            drop_q  <= 1'b0;
        end else begin
            case (state_q)
                UNC_IDLE: if (start_i) state_q <= UNC_REQ;
                UNC_REQ:  if (req_ready_i) state_q <= UNC_WAIT;
                UNC_WAIT: if (rsp_valid_i) state_q <= UNC_IDLE;
                default:  state_q <= UNC_IDLE;
            endcase
            if (state_q == UNC_IDLE)
                drop_q <= 1'b0;
            else if (flush_i)
                drop_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == UNC_IDLE && start_i)
            addr_q <= addr_i;
    end

    assign req_valid_o = state_q == UNC_REQ;
    assign req_o       = '{addr: addr_q, line: 1'b0};
    assign done_o      = rsp_valid_i && state_q == UNC_WAIT && !drop_q && !flush_i;
    assign word_o      = rsp_word_i;
    assign busy_o      = state_q != UNC_IDLE;

endmodule

`default_nettype wire

// File: src/icache.sv
`default_nettype none

module icache #(
    parameter int SETS = icache_pkg::SET_NUM
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush_i,
    input  icache_pkg::fetch_req_t        fetch_req_i,
    input  icache_pkg::cacop_t            cacop_i,
    output logic                          stall_o,
    output icache_pkg::fetch_rsp_t        fetch_rsp_o,
    output logic                          line_req_valid_o,
    output icache_pkg::mem_req_t          line_req_o,
    input  logic                          line_req_ready_i,
    input  logic                          line_rsp_valid_i,
    input  logic [icache_pkg::LINE_W-1:0] line_rsp_data_i,
    output logic                          word_req_valid_o,
    output icache_pkg::mem_req_t          word_req_o,
    input  logic                          word_req_ready_i,
    input  logic                          word_rsp_valid_i,
    input  logic [31:0]                   word_rsp_word_i
);
    import icache_pkg::*;

    localparam int IDX_W = $clog2(SETS);

    logic               init_busy;
    logic [IDX_W-1:0]   init_cnt;

    logic               s1_valid;
    logic [31:0]        s1_pc;
    logic               s1_unc;
    logic               stale_q;  // arrays written under the last read
    logic               accept;
    logic [IDX_W-1:0]   rd_idx;
    logic [IDX_W-1:0]   s1_idx;
    logic [TAG_W-1:0]   s1_tag;
    logic [OFFSET_W-3:0] s1_off;

    logic [31:0]        bank_rd [2][BANK_NUM];
    tagv_t              tag_rd [2];
    tagv_t              tag_wdata;
    logic [IDX_W-1:0]   tag_waddr;
    logic [1:0]         tag_we;
    logic [1:0]         data_we;
    logic [IDX_W-1:0]   fill_idx;
    logic [TAG_W-1:0]   fill_tag;
    logic               cacop_inv;

    logic [1:0]         hit;
    logic               eval;
    logic               s1_hit;
    logic               s1_miss;
    logic               miss;
    logic               unc_start;
    logic [SETS-1:0]    lru_q;  // way to replace next
    logic               victim;

    logic               refill_busy;
    logic               fill;
    logic               fill_live;
    logic [LINE_W-1:0]  fill_data;
    logic               unc_busy;
    logic               unc_done;
    logic [31:0]        unc_word;

    logic               rsp_valid_q;
    logic [31:0]        rsp_pc_q;
    logic [31:0]        rsp_inst_q;
    logic [31:0]        inst_sel;

    assign s1_idx    = s1_pc[OFFSET_W +: IDX_W];
    assign s1_tag    = s1_pc[OFFSET_W+INDEX_W +: TAG_W];
    assign s1_off    = s1_pc[2 +: OFFSET_W-2];
    assign fill_idx  = line_req_o.addr[OFFSET_W +: IDX_W];  // held line address of the refill
    assign fill_tag  = line_req_o.addr[OFFSET_W+INDEX_W +: TAG_W];
    assign cacop_inv = cacop_i.en && cacop_i.mode != CACOP_NONE;

    assign stall_o = init_busy || (!flush_i && (cacop_i.en || stale_q || fill
                     || (s1_valid && !s1_hit && !unc_done)));
    assign accept  = fetch_req_i.valid && !stall_o;
    assign rd_idx  = stall_o ? s1_idx : fetch_req_i.pc[OFFSET_W +: IDX_W];

    // tag sweep after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            init_busy <= 1'b1;
            init_cnt  <= '0;
        end else if (init_busy) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == IDX_W'(SETS - 1))
                init_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            stale_q  <= 1'b0;
        end else begin
            stale_q <= fill || cacop_i.en;
            if (accept)
                s1_valid <= 1'b1;
            else if (flush_i || s1_hit || fill_live || unc_done)
                s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_pc  <= fetch_req_i.pc;
            s1_unc <= fetch_req_i.uncached;
        end
    end

    assign victim  = lru_q[fill_idx];
    assign data_we = fill ? (victim ? 2'b10 : 2'b01) : 2'b00;
    assign tag_we  = (init_busy || cacop_inv) ? 2'b11 : data_we;

    // cacop wins over a fill in the same cycle
    always_comb begin
        tag_waddr = fill_idx;
        tag_wdata = '{valid: 1'b1, tag: fill_tag};
        if (init_busy) begin
            tag_waddr = init_cnt;
            tag_wdata = '0;
        end else if (cacop_inv) begin
            tag_waddr = cacop_i.addr[OFFSET_W +: IDX_W];
            tag_wdata = '0;
        end
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < BANK_NUM; b++) begin : g_bank
            sdp_ram #(
                .DEPTH(SETS),
                .WIDTH(32)
            ) u_bank (
                .clk    (clk),
                .we_i   (data_we[w]),
                .waddr_i(fill_idx),
                .raddr_i(rd_idx),
                .wdata_i(fill_data[b*32 +: 32]),
                .rdata_o(bank_rd[w][b])
            );
        end

        sdp_ram #(
            .DEPTH(SETS),
            .WIDTH($bits(tagv_t))
        ) u_tagv (
            .clk    (clk),
            .we_i   (tag_we[w]),
            .waddr_i(tag_waddr),
            .raddr_i(rd_idx),
            .wdata_i(tag_wdata),
            .rdata_o(tag_rd[w])
        );

        assign hit[w] = tag_rd[w].valid && tag_rd[w].tag == s1_tag;
    end

    // no decision on a read that a write just overtook
    assign eval      = s1_valid && !stale_q && !fill;
    assign s1_hit    = eval && !s1_unc && |hit;
    assign s1_miss   = eval && !s1_unc && !(|hit);
    assign miss      = s1_miss && !refill_busy && !flush_i;
    assign unc_start = eval && s1_unc && !unc_busy && !flush_i;

    always_ff @(posedge clk) begin
        if (reset)
            lru_q <= '0;
        else if (fill)
            lru_q[fill_idx] <= !victim;
        else if (s1_hit && !flush_i)
            lru_q[s1_idx] <= hit[0];
    end

    icache_refill u_refill (
        .clk        (clk),
        .reset      (reset),
        .flush_i    (flush_i),
        .miss_i     (miss),
        .miss_addr_i(s1_pc),
        .req_valid_o(line_req_valid_o),
        .req_o      (line_req_o),
        .req_ready_i(line_req_ready_i),
        .rsp_valid_i(line_rsp_valid_i),
        .rsp_data_i (line_rsp_data_i),
        .fill_o     (fill),
        .fill_live_o(fill_live),
        .fill_data_o(fill_data),
        .busy_o     (refill_busy)
    );

    icache_uncached u_uncached (
        .clk        (clk),
        .reset      (reset),
        .flush_i    (flush_i),
        .start_i    (unc_start),
        .addr_i     (s1_pc),
        .req_valid_o(word_req_valid_o),
        .req_o      (word_req_o),
        .req_ready_i(word_req_ready_i),
        .rsp_valid_i(word_rsp_valid_i),
        .rsp_word_i (word_rsp_word_i),
        .done_o     (unc_done),
        .word_o     (unc_word),
        .busy_o     (unc_busy)
    );

    always_comb begin
        if (unc_done)
            inst_sel = unc_word;
        else if (fill_live)
            inst_sel = fill_data[s1_off*32 +: 32];  // forward from the line
        else if (hit[1])
            inst_sel = bank_rd[1][s1_off];
        else
            inst_sel = bank_rd[0][s1_off];
    end

    always_ff @(posedge clk) begin
        if (reset)
            rsp_valid_q <= 1'b0;
        else
            rsp_valid_q <= !flush_i && (s1_hit || fill_live || unc_done);
    end

    always_ff @(posedge clk) begin
        rsp_pc_q   <= s1_pc;
        rsp_inst_q <= inst_sel;
    end

    assign fetch_rsp_o = '{valid: rsp_valid_q, pc: rsp_pc_q, inst: rsp_inst_q};

endmodule

`default_nettype wire

// File: src/icache_mem_arb.sv
`default_nettype none

module icache_mem_arb (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          line_req_valid_i,
    input  icache_pkg::mem_req_t          line_req_i,
    output logic                          line_req_ready_o,
    output logic                          line_rsp_valid_o,
    output logic [icache_pkg::LINE_W-1:0] line_rsp_data_o,
    input  logic                          word_req_valid_i,
    input  icache_pkg::mem_req_t          word_req_i,
    output logic                          word_req_ready_o,
    output logic                          word_rsp_valid_o,
    output logic [31:0]                   word_rsp_word_o,
    output logic                          mem_req_valid_o,
    output icache_pkg::mem_req_t          mem_req_o,
    input  logic                          mem_req_ready_i,
    input  logic                          mem_rsp_valid_i,
    input  logic [icache_pkg::LINE_W-1:0] mem_rsp_data_i
);

    logic outst_q;      // one request in flight
    logic own_line_q;
    logic hold_q;       // presented but not yet taken
    logic hold_line_q;
    logic sel_line;

    // keep the choice stable while the port holds off
    assign sel_line = hold_q ? hold_line_q : line_req_valid_i;

    assign mem_req_valid_o  = !outst_q && (line_req_valid_i || word_req_valid_i);
    assign mem_req_o        = sel_line ? line_req_i : word_req_i;
    assign line_req_ready_o = !outst_q && sel_line && mem_req_ready_i;
    assign word_req_ready_o = !outst_q && !sel_line && mem_req_ready_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            outst_q     <= 1'b0;
            own_line_q  <= 1'b0;
            hold_q      <= 1'b0;
            hold_line_q <= 1'b0;
        end else begin
            if (mem_req_valid_o && mem_req_ready_i) begin
                outst_q    <= 1'b1;
                own_line_q <= sel_line;
            end else if (mem_rsp_valid_i) begin
                outst_q <= 1'b0;
            end
            hold_q      <= mem_req_valid_o && !mem_req_ready_i;
            hold_line_q <= sel_line;
        end
    end

    assign line_rsp_valid_o = mem_rsp_valid_i && outst_q && own_line_q;
    assign word_rsp_valid_o = mem_rsp_valid_i && outst_q && !own_line_q;
    assign line_rsp_data_o  = mem_rsp_data_i;
    assign word_rsp_word_o  = mem_rsp_data_i[31:0];  // word sits in the low lane

endmodule

`default_nettype wire

// File: src/icache_top.sv
`default_nettype none

module icache_top #(
    parameter int SETS = icache_pkg::SET_NUM
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush_i,
    input  icache_pkg::fetch_req_t        fetch_req_i,
    input  icache_pkg::cacop_t            cacop_i,
    output logic                          stall_o,
    output icache_pkg::fetch_rsp_t        fetch_rsp_o,
    output logic                          mem_req_valid_o,
    output icache_pkg::mem_req_t          mem_req_o,
    input  logic                          mem_req_ready_i,
    input  logic                          mem_rsp_valid_i,
    input  logic [icache_pkg::LINE_W-1:0] mem_rsp_data_i
);
    import icache_pkg::*;

    logic              line_req_valid;
    mem_req_t          line_req;
    logic              line_req_ready;
    logic              line_rsp_valid;
    logic [LINE_W-1:0] line_rsp_data;
    logic              word_req_valid;
    mem_req_t          word_req;
    logic              word_req_ready;
    logic              word_rsp_valid;
    logic [31:0]       word_rsp_word;

    icache #(
        .SETS(SETS)
    ) u_icache (
        .clk             (clk),
        .reset           (reset),
        .flush_i         (flush_i),
        .fetch_req_i     (fetch_req_i),
        .cacop_i         (cacop_i),
        .stall_o         (stall_o),
        .fetch_rsp_o     (fetch_rsp_o),
        .line_req_valid_o(line_req_valid),
        .line_req_o      (line_req),
        .line_req_ready_i(line_req_ready),
        .line_rsp_valid_i(line_rsp_valid),
        .line_rsp_data_i (line_rsp_data),
        .word_req_valid_o(word_req_valid),
        .word_req_o      (word_req),
        .word_req_ready_i(word_req_ready),
        .word_rsp_valid_i(word_rsp_valid),
        .word_rsp_word_i (word_rsp_word)
    );

    icache_mem_arb u_arb (
        .clk             (clk),
        .reset           (reset),
        .line_req_valid_i(line_req_valid),
        .line_req_i      (line_req),
        .line_req_ready_o(line_req_ready),
        .line_rsp_valid_o(line_rsp_valid),
        .line_rsp_data_o (line_rsp_data),
        .word_req_valid_i(word_req_valid),
        .word_req_i      (word_req),
        .word_req_ready_o(word_req_ready),
        .word_rsp_valid_o(word_rsp_valid),
        .word_rsp_word_o (word_rsp_word),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i)
    );

endmodule

`default_nettype wire

// File: dv/icache_checker.sv
`default_nettype none

module icache_checker (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush_i,
    input  icache_pkg::fetch_req_t        fetch_req_i,
    input  icache_pkg::cacop_t            cacop_i,
    input  logic                          stall_o,
    input  icache_pkg::fetch_rsp_t        fetch_rsp_o,
    input  logic                          mem_req_valid_o,
    input  icache_pkg::mem_req_t          mem_req_o,
    input  logic                          mem_req_ready_i,
    input  logic                          mem_rsp_valid_i,
    input  logic [icache_pkg::LINE_W-1:0] mem_rsp_data_i,
    output int                            errors_o,
    output int                            pending_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import icache_pkg::*;

    typedef struct {
        logic [31:0] pc;
        logic        unc;
        int          acc;      // cycle of acceptance
        logic        exp_hit;
        logic        missed;   // line request seen for it
    } fetch_t;

    fetch_t           pend [$];
    logic [TAG_W-1:0] tag_m [2][SET_NUM];
    logic             valid_m [2][SET_NUM];
    logic             lru_m [SET_NUM];
    int               cycle;
    int               errors;
    logic             out_line;
    logic [31:0]      out_addr;
    logic             cacop_q;  // cacop active in the last cycle

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        return ({a[18:0], a[31:19]} ^ 32'h9e37_79b9) + a;
    endfunction

    function automatic int held_way(input logic [31:0] pc);
        for (int w = 0; w < 2; w++)
            if (valid_m[w][pc[11:5]] && tag_m[w][pc[11:5]] == pc[31:12])
                return w;
        return -1;
    endfunction

    always @(posedge clk) begin : watch
        fetch_t     e;
        int         w;
        logic [6:0] idx;
        cycle = cycle + 1;
        if (reset) begin
            pend.delete();
            out_line = 1'b0;
            cacop_q  = 1'b0;
            for (int s = 0; s < SET_NUM; s++) begin
                valid_m[0][s] = 1'b0;
                valid_m[1][s] = 1'b0;
                lru_m[s]      = 1'b0;
            end
        end else begin
            if (fetch_rsp_o.valid) begin
                if (pend.size() == 0) begin
                    $display("Error at %0t: response with no fetch outstanding", $time);
                    errors++;
                end else begin
                    e = pend.pop_front();
                    w = held_way(e.pc);
                    if (fetch_rsp_o.pc != e.pc || fetch_rsp_o.inst != expected_word(e.pc)) begin
                        $display("Error at %0t: rsp pc %h inst %h, expected pc %h inst %h", $time,
                                 fetch_rsp_o.pc, fetch_rsp_o.inst, e.pc, expected_word(e.pc));
                        errors++;
                    end
                    if (!e.unc) begin
                        if (e.exp_hit && cycle - e.acc != 2) begin
                            $display("Error at %0t: hit at pc %h took %0d cycles", $time, e.pc,
                                     cycle - e.acc - 1);
                            errors++;
                        end
                        if (w < 0 || (!e.exp_hit && !e.missed)) begin
                            $display("Error at %0t: pc %h answered without its line", $time,
                                     e.pc);
                            errors++;
                        end else if (!e.missed) begin
                            lru_m[e.pc[11:5]] = (w == 0);  // point at the other way
                        end
                    end
                end
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                out_line = mem_req_o.line;
                out_addr = mem_req_o.addr;
                foreach (pend[i]) begin
                    if (mem_req_o.line && !pend[i].unc && pend[i].pc[31:5] == out_addr[31:5]) begin
                        if (pend[i].exp_hit) begin
                            $display("Error at %0t: line request for held line %h", $time,
                                     out_addr);
                            errors++;
                        end
                        pend[i].missed = 1'b1;
                    end
                end
                if (pend.size() > 0 && pend[0].unc
                    && (mem_req_o.line || out_addr != pend[0].pc)) begin
                    $display("Error at %0t: request %h line %b, expected word %h", $time,
                             out_addr, mem_req_o.line, pend[0].pc);
                    errors++;
                end
            end
            if (mem_rsp_valid_i && out_line) begin
                idx = out_addr[11:5];
                w = lru_m[idx];
                tag_m[w][idx]   = out_addr[31:12];
                valid_m[w][idx] = 1'b1;
                lru_m[idx]      = !w[0];
            end
            if (mem_rsp_valid_i)
                out_line = 1'b0;
            if (cacop_i.en && cacop_i.mode != CACOP_NONE) begin
                valid_m[0][cacop_i.addr[11:5]] = 1'b0;
                valid_m[1][cacop_i.addr[11:5]] = 1'b0;
            end
            if (!flush_i && (cacop_i.en || cacop_q) && !stall_o) begin
                $display("Error at %0t: stall_o low around a cacop", $time);
                errors++;
            end
            if (flush_i && stall_o) begin
                $display("Error at %0t: stall_o high during a flush", $time);
                errors++;
            end
            cacop_q = cacop_i.en;
            if (flush_i)
                pend.delete();
            if (fetch_req_i.valid && !stall_o) begin
                e.pc      = fetch_req_i.pc;
                e.unc     = fetch_req_i.uncached;
                e.acc     = cycle;
                e.exp_hit = !fetch_req_i.uncached && held_way(fetch_req_i.pc) >= 0;
                e.missed  = 1'b0;
                pend.push_back(e);
            end
            if (pend.size() > 0 && cycle - pend[0].acc > 300) begin
                $display("fetch at pc %h never got a response", pend[0].pc);
                errors++;
                void'(pend.pop_front());
            end
        end
    end

    assign errors_o  = errors;
    assign pending_o = pend.size();

endmodule

`default_nettype wire

// File: dv/icache_tb.sv
`default_nettype none

module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import icache_pkg::*;

    localparam int N_RAND       = 300;
    localparam int N_FETCH      = N_RAND + 8;
    localparam int WORST_MISS   = 40;  // two 6-cycle delays, pipeline and quiet waits
    localparam int RESET_CYCLES = 3 + SET_NUM + 8;
    localparam int LIMIT        = N_FETCH * WORST_MISS + RESET_CYCLES;

    logic              clk;
    logic              reset;
    logic              flush_i;
    fetch_req_t        fetch_req_i;
    cacop_t            cacop_i;
    logic              stall_o;
    fetch_rsp_t        fetch_rsp_o;
    logic              mem_req_valid_o;
    mem_req_t          mem_req_o;
    logic              mem_req_ready_i;
    logic              mem_rsp_valid_i;
    logic [LINE_W-1:0] mem_rsp_data_i;
    logic              mem_busy;
    int                errors;
    int                pending;
    int                cycles = 0;
    logic [19:0]       tag_pool [4] = '{20'h12345, 20'h00abc, 20'h7f001, 20'h01010};
    logic [6:0]        idx_pool [3] = '{7'd5, 7'd6, 7'd77};

    icache_top #(.SETS(SET_NUM)) u_dut (.*);

    icache_checker u_chk (.*, .errors_o(errors), .pending_o(pending));

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return ({a[18:0], a[31:19]} ^ 32'h9e37_79b9) + a;
    endfunction

    function automatic logic [LINE_W-1:0] line_data(input logic [31:0] a);
        logic [LINE_W-1:0] d;
        for (int k = 0; k < BANK_NUM; k++)
            d[k*32 +: 32] = mem_word({a[31:5], 3'(k), 2'b00});
        return d;
    endfunction

    function automatic logic [31:0] pool_pc();
        return {tag_pool[$urandom_range(3)], idx_pool[$urandom_range(2)],
                3'($urandom_range(7)), 2'b00};
    endfunction

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    // present a fetch and hold it until the cache takes it
    task automatic fetch(input logic [31:0] pc, input logic unc);
        fetch_req_i = '{valid: 1'b1, pc: pc, uncached: unc};
        #1;
        while (stall_o) begin
            @(posedge clk);
            #2;
        end
        next_edge();
        fetch_req_i.valid = 1'b0;
    endtask

    task automatic flush_pulse();
        flush_i = 1'b1;
        next_edge();
        flush_i = 1'b0;
    endtask

    task automatic cacop_pulse(input cacop_mode_e mode, input logic [31:0] addr);
        cacop_i = '{en: 1'b1, mode: mode, addr: addr};
        next_edge();
        cacop_i.en = 1'b0;
    endtask

    task automatic wait_quiet();
        int quiet;
        quiet = 0;
        while (quiet < 3) begin
            next_edge();
            if (!mem_req_valid_o && !mem_busy && pending == 0 && !stall_o)
                quiet++;
            else
                quiet = 0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run went past %0d cycles", LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // memory model, one request at a time
    initial begin : responder
        mem_req_t req;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i  = '0;
        mem_busy        = 1'b0;
        forever begin
            next_edge();
            mem_rsp_valid_i = 1'b0;
            mem_busy        = 1'b0;
            if (mem_req_valid_o) begin
                mem_busy = 1'b1;
                repeat ($urandom_range(6)) next_edge();
                mem_req_ready_i = 1'b1;
                req = mem_req_o;
                next_edge();
                mem_req_ready_i = 1'b0;
                repeat ($urandom_range(6)) next_edge();
                mem_rsp_valid_i = 1'b1;
                mem_rsp_data_i  = req.line ? line_data(req.addr) : {224'h0, mem_word(req.addr)};
            end
        end
    end

    initial begin
        int          pick;
        logic [31:0] pc;
        void'($urandom(32'h0698_bd7f));
        reset       = 1'b1;
        flush_i     = 1'b0;
        fetch_req_i = '0;
        cacop_i     = '0;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        while (stall_o) next_edge();

        // A B A C at one set evicts B
        fetch({20'h00a0a, 7'd9, 5'h04}, 1'b0);
        fetch({20'h00b0b, 7'd9, 5'h08}, 1'b0);
        fetch({20'h00a0a, 7'd9, 5'h0c}, 1'b0);
        fetch({20'h00c0c, 7'd9, 5'h10}, 1'b0);
        fetch({20'h00a0a, 7'd9, 5'h14}, 1'b0);
        fetch({20'h00b0b, 7'd9, 5'h18}, 1'b0);
        wait_quiet();
        fetch({20'h00d0d, 7'd9, 5'h00}, 1'b1);  // uncached, then the same line cached
        fetch({20'h00d0d, 7'd9, 5'h00}, 1'b0);
        wait_quiet();

        for (int i = 0; i < N_RAND; i++) begin
            pick = $urandom_range(99);
            pc   = pool_pc();
            if (pick < 6) begin
                wait_quiet();
                cacop_pulse(cacop_mode_e'($urandom_range(3)), pc);
            end else if (pick < 14) begin
                fetch(pc, 1'b1);
            end else if (pick < 20) begin
                fetch(pc, pick >= 17);  // flush a miss or an uncached read
                repeat ($urandom_range(3)) next_edge();
                flush_pulse();
                wait_quiet();
            end else begin
                fetch(pc, 1'b0);
            end
        end
        wait_quiet();

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: icache_sub.f
src/icache_pkg.sv
src/sdp_ram.sv
src/icache_refill.sv
src/icache_uncached.sv
src/icache.sv
src/icache_mem_arb.sv
src/icache_top.sv
dv/icache_checker.sv
dv/icache_tb.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing
LINT_TOP  = icache_top
TOP       = icache_tb
FILELIST  = icache_sub.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Result: FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
